// File: design/io_pkg.sv
//////////////////////////////////////////////////
// IO subsystem package
// Pad map, pad variants, register map and bus types
//////////////////////////////////////////////////
package io_pkg;

  localparam int NUM_PADS = 10;  // 0-7 muxed, 8 USB_P, 9 USB_N
  localparam int DATA_W   = 16;
  localparam int ADDR_W   = 3;

  typedef logic [NUM_PADS-1:0] pad_vec_t;

  typedef enum logic [1:0] {
    VAR_BIDIR    = 2'd0,
    VAR_INPUT    = 2'd1,
    VAR_TOLERANT = 2'd2,
    VAR_OPEN_DR  = 2'd3
  } pad_variant_e;

  // Pad types, entry 0 is pad 0
  localparam pad_variant_e PAD_VARIANT [NUM_PADS] = '{
    VAR_BIDIR,     // Pad 0
    VAR_BIDIR,     // Pad 1
    VAR_BIDIR,     // Pad 2
    VAR_BIDIR,     // Pad 3, strap 0
    VAR_BIDIR,     // Pad 4, strap 1
    VAR_INPUT,     // Pad 5
    VAR_OPEN_DR,   // Pad 6
    VAR_OPEN_DR,   // Pad 7
    VAR_TOLERANT,  // USB_P
    VAR_TOLERANT   // USB_N
  };

  localparam int USB_P_IDX   = 8;
  localparam int USB_N_IDX   = 9;
  localparam int STRAP0_IDX  = 3;
  localparam int STRAP1_IDX  = 4;
  localparam int STRAP_DELAY = 4;  // Cycles after reset release
  localparam int STRAP_CNT_W = $clog2(STRAP_DELAY + 1);

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  localparam logic [ADDR_W-1:0] ADDR_OUT   = ADDR_W'(0);
  localparam logic [ADDR_W-1:0] ADDR_OE    = ADDR_W'(1);
  localparam logic [ADDR_W-1:0] ADDR_INV   = ADDR_W'(2);
  localparam logic [ADDR_W-1:0] ADDR_IN    = ADDR_W'(3);  // Read-only
  localparam logic [ADDR_W-1:0] ADDR_STRAP = ADDR_W'(4);  // Written by sampler only
  localparam logic [ADDR_W-1:0] ADDR_USB   = ADDR_W'(5);

  localparam int IN_USB_BIT = NUM_PADS;  // Diff input above the pads

  // USB control bits
  localparam int USB_CTRL_W = 5;
  localparam int USB_RX_EN  = 0;
  localparam int USB_DP_OUT = 1;
  localparam int USB_DP_OE  = 2;
  localparam int USB_DN_OUT = 3;
  localparam int USB_DN_OE  = 4;

  typedef enum logic {
    SRC_HOST  = 1'b0,
    SRC_STRAP = 1'b1
  } reg_src_e;

  typedef struct packed {
    logic              strobe;
    logic              write;
    reg_src_e          src;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } reg_rsp_t;

  typedef struct packed {
    pad_vec_t out;
    pad_vec_t oe;
    pad_vec_t inv;
  } pad_ctrl_t;

endpackage

// File: design/io_reg_arbiter.sv
//////////////////////////////////////////////////
// Register port arbiter
// Fixed priority to the host, sampler gets one grant
//////////////////////////////////////////////////
module io_reg_arbiter
  import io_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t host_req_i,
  input  reg_req_t strap_req_i,
  output logic     strap_grant_o,
  output reg_req_t req_o
);

  logic strap_done_q;  // Sampler already served

  // Sampler only fills cycles without a host strobe
  assign strap_grant_o = strap_req_i.strobe &
                         ~host_req_i.strobe &
                         ~strap_done_q;

  // Same-cycle forward, no buffering
  assign req_o = strap_grant_o ? strap_req_i : host_req_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      strap_done_q <= 1'b0;
    end else if (strap_grant_o) begin
      strap_done_q <= 1'b1;  // Held until next reset
    end
  end

endmodule

// File: design/io_reg_file.sv
//////////////////////////////////////////////////
// Pad control register file
// OUT/OE/INV/STRAP/USB registers and read response
//////////////////////////////////////////////////
module io_reg_file
  import io_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  reg_req_t              req_i,
  output reg_rsp_t              rsp_o,
  input  pad_vec_t              pad_in_sync_i,
  input  logic                  usb_diff_in_i,
  output pad_ctrl_t             ctrl_o,
  output logic [USB_CTRL_W-1:0] usb_ctrl_o
);

  pad_vec_t              out_q;
  pad_vec_t              oe_q;
  pad_vec_t              inv_q;
  logic [1:0]            strap_q;
  logic [USB_CTRL_W-1:0] usb_q;

  logic              host_we;
  logic              strap_we;
  logic              rd_en;
  logic [DATA_W-1:0] rdata_d;
  logic              rsp_valid_q;
  logic [DATA_W-1:0] rsp_rdata_q;

  //////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////

  // Access rights follow the request source
  assign host_we  = req_i.strobe & req_i.write & (req_i.src == SRC_HOST);
  assign strap_we = req_i.strobe & req_i.write & (req_i.src == SRC_STRAP);
  assign rd_en    = req_i.strobe & ~req_i.write;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
      inv_q <= '0;
      usb_q <= '0;
    end else if (host_we) begin
      case (req_i.addr)
        ADDR_OUT: out_q <= req_i.wdata[NUM_PADS-1:0];
        ADDR_OE:  oe_q  <= req_i.wdata[NUM_PADS-1:0];
        ADDR_INV: inv_q <= req_i.wdata[NUM_PADS-1:0];
        ADDR_USB: usb_q <= req_i.wdata[USB_CTRL_W-1:0];
        default:  ;  // IN and STRAP are read-only to the host
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      strap_q <= '0;
    end else if (strap_we && req_i.addr == ADDR_STRAP) begin
      strap_q <= req_i.wdata[1:0];  // Sampler may touch STRAP only
    end
  end

  //////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////

  always_comb begin
    case (req_i.addr)
      ADDR_OUT:   rdata_d = DATA_W'(out_q);
      ADDR_OE:    rdata_d = DATA_W'(oe_q);
      ADDR_INV:   rdata_d = DATA_W'(inv_q);
      ADDR_IN:    rdata_d = DATA_W'({usb_diff_in_i, pad_in_sync_i});
      ADDR_STRAP: rdata_d = DATA_W'(strap_q);
      ADDR_USB:   rdata_d = DATA_W'(usb_q);
      default:    rdata_d = '0;  // Unmapped
    endcase
  end

  // Response one cycle after the read strobe
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rd_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rsp_rdata_q <= rdata_d;
    end
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.rdata = rsp_rdata_q;

  assign ctrl_o.out  = out_q;
  assign ctrl_o.oe   = oe_q;
  assign ctrl_o.inv  = inv_q;
  assign usb_ctrl_o  = usb_q;

endmodule

// File: design/pad_bank.sv
//////////////////////////////////////////////////
// Pad bank
// Variant rules on outputs, input synchronizers
//////////////////////////////////////////////////
module pad_bank
  import io_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  pad_ctrl_t ctrl_i,
  input  pad_vec_t  pad_in_i,
  output pad_vec_t  pad_out_o,
  output pad_vec_t  pad_oe_o,
  output pad_vec_t  pad_in_sync_o
);

  pad_vec_t out_val;
  pad_vec_t sync_q1;
  pad_vec_t sync_q2;

  //////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////

  assign out_val = ctrl_i.out ^ ctrl_i.inv;  // Invert applies before the pad

  for (genvar i = 0; i < NUM_PADS; i++) begin : gen_pad
    if (PAD_VARIANT[i] == VAR_INPUT) begin : gen_input
      // Receiver only, never drives
      assign pad_out_o[i] = 1'b0;
      assign pad_oe_o[i]  = 1'b0;
    end else if (PAD_VARIANT[i] == VAR_OPEN_DR) begin : gen_open_drain
      // Pulls low only, a 1 is left to the external pull-up
      assign pad_out_o[i] = 1'b0;
      assign pad_oe_o[i]  = ctrl_i.oe[i] & ~out_val[i];
    end else begin : gen_bidir
      // Bidirectional and tolerant pads behave the same here
      assign pad_out_o[i] = out_val[i];
      assign pad_oe_o[i]  = ctrl_i.oe[i];
    end
  end

  //////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pad_in_i;  // First stage, may go metastable
      sync_q2 <= sync_q1;
    end
  end

  // Same invert as the output path
  assign pad_in_sync_o = sync_q2 ^ ctrl_i.inv;

endmodule

// File: design/usb_overlay.sv
//////////////////////////////////////////////////
// USB overlay
// Differential receive and pull-up enables
//////////////////////////////////////////////////
module usb_overlay
  import io_pkg::*;
(
  input  logic [USB_CTRL_W-1:0] usb_ctrl_i,
  input  logic                  usb_p_i,
  input  logic                  usb_n_i,
  output logic                  usb_diff_in_o,
  output logic                  usb_pullup_p_o,
  output logic                  usb_pullup_n_o
);

  logic rx_en;
  logic diff_j;

  assign rx_en  = usb_ctrl_i[USB_RX_EN];
  assign diff_j = usb_p_i & ~usb_n_i;  // J state on the line

  // Receiver output held low while disabled
  assign usb_diff_in_o = rx_en & diff_j;

  // A pull-up is on only with both its value and enable set
  assign usb_pullup_p_o = usb_ctrl_i[USB_DP_OUT] & usb_ctrl_i[USB_DP_OE];
  assign usb_pullup_n_o = usb_ctrl_i[USB_DN_OUT] & usb_ctrl_i[USB_DN_OE];

endmodule

// File: design/strap_sampler.sv
//////////////////////////////////////////////////
// Strap sampler
// Captures the strap pads once after reset
//////////////////////////////////////////////////
module strap_sampler
  import io_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  pad_vec_t pad_in_sync_i,
  input  logic     grant_i,
  output reg_req_t req_o
);

  typedef enum logic [1:0] {
    ST_WAIT,
    ST_REQ,
    ST_DONE
  } state_e;

  state_e                 state_q;
  logic [STRAP_CNT_W-1:0] cnt_q;
  logic [1:0]             strap_q;
  logic                   sample;

  assign sample = (state_q == ST_WAIT) && (cnt_q == STRAP_CNT_W'(STRAP_DELAY - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_WAIT;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_WAIT: begin
          cnt_q <= cnt_q + 1'b1;
          if (sample) begin
            state_q <= ST_REQ;
          end
        end
        ST_REQ:  if (grant_i) state_q <= ST_DONE;  // Hold strobe until granted
        default: ;  // Idle until next reset
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (sample) begin
      strap_q <= {pad_in_sync_i[STRAP1_IDX], pad_in_sync_i[STRAP0_IDX]};
    end
  end

  assign req_o.strobe = (state_q == ST_REQ);
  assign req_o.write  = 1'b1;
  assign req_o.src    = SRC_STRAP;
  assign req_o.addr   = ADDR_STRAP;
  assign req_o.wdata  = DATA_W'(strap_q);

endmodule

// File: design/io_top.sv
//////////////////////////////////////////////////
// IO subsystem top
// Host and strap peers, register file, pads, USB
//////////////////////////////////////////////////
module io_top
  import io_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t host_req_i,
  output reg_rsp_t host_rsp_o,
  input  pad_vec_t pad_in_i,
  output pad_vec_t pad_out_o,
  output pad_vec_t pad_oe_o,
  output logic     usb_pullup_p_o,
  output logic     usb_pullup_n_o
);

  reg_req_t              strap_req;
  logic                  strap_grant;
  reg_req_t              reg_req;
  pad_ctrl_t             pad_ctrl;
  pad_vec_t              pad_in_sync;
  logic [USB_CTRL_W-1:0] usb_ctrl;
  logic                  usb_diff_in;

  //////////////////////////////////////////////////
  // Register access
  //////////////////////////////////////////////////

  strap_sampler u_strap_sampler (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .pad_in_sync_i ( pad_in_sync ),
    .grant_i       ( strap_grant ),
    .req_o         ( strap_req   )
  );

  io_reg_arbiter u_io_reg_arbiter (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .host_req_i    ( host_req_i  ),
    .strap_req_i   ( strap_req   ),
    .strap_grant_o ( strap_grant ),
    .req_o         ( reg_req     )
  );

  io_reg_file u_io_reg_file (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .req_i         ( reg_req     ),
    .rsp_o         ( host_rsp_o  ),
    .pad_in_sync_i ( pad_in_sync ),
    .usb_diff_in_i ( usb_diff_in ),
    .ctrl_o        ( pad_ctrl    ),
    .usb_ctrl_o    ( usb_ctrl    )
  );

  //////////////////////////////////////////////////
  // Pads and USB
  //////////////////////////////////////////////////

  pad_bank u_pad_bank (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .ctrl_i        ( pad_ctrl    ),
    .pad_in_i      ( pad_in_i    ),
    .pad_out_o     ( pad_out_o   ),
    .pad_oe_o      ( pad_oe_o    ),
    .pad_in_sync_o ( pad_in_sync )
  );

  usb_overlay u_usb_overlay (
    .usb_ctrl_i     ( usb_ctrl               ),
    .usb_p_i        ( pad_in_sync[USB_P_IDX] ),  // Synced line states
    .usb_n_i        ( pad_in_sync[USB_N_IDX] ),
    .usb_diff_in_o  ( usb_diff_in            ),
    .usb_pullup_p_o ( usb_pullup_p_o         ),
    .usb_pullup_n_o ( usb_pullup_n_o         )
  );

endmodule

// File: sim/io_top_assert.sv
//////////////////////////////////////////////////
// IO top assertions
// Pad variant rules and read response timing
//////////////////////////////////////////////////
module io_top_assert
  import io_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input reg_req_t host_req_i,
  input reg_rsp_t host_rsp_i,
  input pad_vec_t pad_out_i,
  input pad_vec_t pad_oe_i
);

  for (genvar i = 0; i < NUM_PADS; i++) begin : gen_pad
    if (PAD_VARIANT[i] == VAR_INPUT) begin : gen_input
      a_input_no_oe: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !pad_oe_i[i]
      ) else $error("Input-only pad %0d has oe set", i);
    end else if (PAD_VARIANT[i] == VAR_OPEN_DR) begin : gen_open_drain
      a_od_no_high: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(pad_oe_i[i] && pad_out_i[i])
      ) else $error("Open-drain pad %0d drives high", i);
    end
  end

  a_rsp_after_read: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (host_req_i.strobe && !host_req_i.write) |=> host_rsp_i.valid
  ) else $error("No response one cycle after a read strobe");

  a_rsp_only_after_read: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    host_rsp_i.valid |-> $past(host_req_i.strobe && !host_req_i.write)
  ) else $error("Response valid without a read strobe one cycle before");

endmodule

bind io_top io_top_assert u_io_top_assert (
  .clk_i      ( clk_i      ),
  .rst_n_i    ( rst_n_i    ),
  .host_req_i ( host_req_i ),
  .host_rsp_i ( host_rsp_o ),
  .pad_out_i  ( pad_out_o  ),
  .pad_oe_i   ( pad_oe_o   )
);

// File: sim/tb_io_top.sv
//////////////////////////////////////////////////
// IO subsystem testbench
// Table-driven register, pad, strap and USB checks
//////////////////////////////////////////////////
module tb_io_top
  import io_pkg::*;
();

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] exp;   // Read entries only
  } step_t;

  logic        clk;
  logic        rst_n;
  reg_req_t    host_req;
  reg_rsp_t    host_rsp;
  pad_vec_t    pad_in;
  pad_vec_t    pad_out;
  pad_vec_t    pad_oe;
  logic        pullup_p;
  logic        pullup_n;
  int          err_cnt;
  int          chk_cnt;
  logic [31:0] lcg_state;

  // Strap readback, register readback and unmapped reads
  step_t steps [19] = '{
    '{ADDR_STRAP, 1'b0, 16'h0000, 16'h0001},  // Pad 3 high, pad 4 low
    '{ADDR_STRAP, 1'b1, 16'h0002, 16'h0000},  // Host write is dropped
    '{ADDR_STRAP, 1'b0, 16'h0000, 16'h0001},
    '{ADDR_IN,    1'b1, 16'hffff, 16'h0000},
    '{ADDR_OUT,   1'b1, 16'h02a5, 16'h0000},
    '{ADDR_OUT,   1'b0, 16'h0000, 16'h02a5},
    '{ADDR_OE,    1'b1, 16'hffff, 16'h0000},
    '{ADDR_OE,    1'b0, 16'h0000, 16'h03ff},  // One bit per pad
    '{ADDR_INV,   1'b1, 16'h0155, 16'h0000},
    '{ADDR_INV,   1'b0, 16'h0000, 16'h0155},
    '{ADDR_USB,   1'b1, 16'h001f, 16'h0000},
    '{ADDR_USB,   1'b0, 16'h0000, 16'h001f},
    '{ADDR_USB,   1'b1, 16'hffea, 16'h0000},
    '{ADDR_USB,   1'b0, 16'h0000, 16'h000a},  // Five control bits
    '{3'd6,       1'b1, 16'h1234, 16'h0000},
    '{3'd6,       1'b0, 16'h0000, 16'h0000},
    '{3'd7,       1'b0, 16'h0000, 16'h0000},
    '{ADDR_INV,   1'b1, 16'h0000, 16'h0000},
    '{ADDR_INV,   1'b0, 16'h0000, 16'h0000}
  };

  io_top dut_i (
    .clk_i          ( clk      ),
    .rst_n_i        ( rst_n    ),
    .host_req_i     ( host_req ),
    .host_rsp_o     ( host_rsp ),
    .pad_in_i       ( pad_in   ),
    .pad_out_o      ( pad_out  ),
    .pad_oe_o       ( pad_oe   ),
    .usb_pullup_p_o ( pullup_p ),
    .usb_pullup_n_o ( pullup_n )
  );

  always begin
    clk = 1'b0;
    #4;
    clk = 1'b1;
    #4;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_pads(output pad_vec_t v);
    lcg_state = lcg_next(lcg_state);
    v = lcg_state[25:16];  // Upper bits have the longer period
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(posedge clk);
    host_req <= '{strobe: 1'b1, write: 1'b1, src: SRC_HOST, addr: addr, wdata: data};
    @(posedge clk);
    host_req.strobe <= 1'b0;  // Single-cycle strobe
  endtask

  task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    int   n;
    logic got;
    @(posedge clk);
    host_req <= '{strobe: 1'b1, write: 1'b0, src: SRC_HOST, addr: addr, wdata: '0};
    @(posedge clk);
    host_req.strobe <= 1'b0;
    got = 1'b0;
    for (n = 0; n < 16 && !got; n++) begin
      @(negedge clk);
      got = host_rsp.valid;
    end
    if (!got) begin
      err_cnt++;
      $display("Timeout: no read response from address %0d", addr);
      data = '0;
    end else begin
      data = host_rsp.rdata;
    end
  endtask

  // Expected pad drive from the variant rules
  task automatic check_pads(input pad_vec_t out_r, input pad_vec_t oe_r, input pad_vec_t inv_r);
    pad_vec_t val;
    pad_vec_t exp_oe;
    pad_vec_t exp_out;
    pad_vec_t care;
    int       i;
    val = out_r ^ inv_r;
    for (i = 0; i < NUM_PADS; i++) begin
      exp_oe[i]  = oe_r[i];
      exp_out[i] = val[i];
      care[i]    = 1'b1;
      if (PAD_VARIANT[i] == VAR_INPUT) begin
        exp_oe[i] = 1'b0;  // Never drives
        care[i]   = 1'b0;
      end else if (PAD_VARIANT[i] == VAR_OPEN_DR) begin
        exp_oe[i]  = oe_r[i] & ~val[i];  // Pulls low only
        exp_out[i] = 1'b0;
        care[i]    = exp_oe[i];
      end
    end
    check_value("pad_oe", 32'(pad_oe), 32'(exp_oe));
    check_value("pad_out", 32'(pad_out & care), 32'(exp_out & care));
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    int                s;
    int                r;
    int                p;
    logic [3:0]        pat;
    pad_vec_t          out_v;
    pad_vec_t          oe_v;
    pad_vec_t          inv_v;
    pad_vec_t          in_v;
    logic [DATA_W-1:0] rdata;
    lcg_state = 32'h5c26;
    err_cnt   = 0;
    chk_cnt   = 0;
    rst_n    <= 1'b0;
    host_req <= '0;
    pad_in   <= pad_vec_t'(1 << STRAP0_IDX);  // Strap 0 high, strap 1 low

    repeat (9) @(posedge clk);
    @(negedge clk);
    check_value("pad_oe in reset", 32'(pad_oe), 32'd0);
    check_value("pad_out in reset", 32'(pad_out), 32'd0);
    check_value("pull-ups in reset", 32'({pullup_n, pullup_p}), 32'd0);
    check_value("rsp valid in reset", 32'(host_rsp.valid), 32'd0);
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (20) @(posedge clk);  // Strap capture window

    for (s = 0; s < $size(steps); s++) begin
      if (steps[s].write) begin
        reg_write(steps[s].addr, steps[s].data);
      end else begin
        reg_read(steps[s].addr, rdata);
        check_value($sformatf("step %0d read", s), 32'(rdata), 32'(steps[s].exp));
      end
    end

    // Output rules, plain then inverted
    for (r = 0; r < 4; r++) begin
      draw_pads(out_v);
      draw_pads(oe_v);
      draw_pads(inv_v);
      if (r < 2) begin
        inv_v = '0;
      end
      reg_write(ADDR_OUT, DATA_W'(out_v));
      reg_write(ADDR_OE, DATA_W'(oe_v));
      reg_write(ADDR_INV, DATA_W'(inv_v));
      @(negedge clk);
      check_pads(out_v, oe_v, inv_v);
    end

    // Input path through the synchronizers
    reg_write(ADDR_USB, '0);
    for (r = 0; r < 3; r++) begin
      draw_pads(in_v);
      @(posedge clk);
      pad_in <= in_v;
      repeat (4) @(posedge clk);
      reg_read(ADDR_IN, rdata);
      check_value("IN pads", 32'(rdata), 32'(DATA_W'(in_v ^ inv_v)));
    end

    // USB receive and pull-ups
    reg_write(ADDR_INV, '0);
    reg_write(ADDR_USB, 16'h0001);  // Rx enable
    @(posedge clk);
    pad_in <= pad_vec_t'(1 << USB_P_IDX);  // P high, N low
    repeat (4) @(posedge clk);
    reg_read(ADDR_IN, rdata);
    check_value("IN with rx on", 32'(rdata), 32'h0500);
    reg_write(ADDR_USB, '0);
    reg_read(ADDR_IN, rdata);
    check_value("IN with rx off", 32'(rdata), 32'h0100);
    for (p = 0; p < 16; p++) begin
      pat = 4'(p);
      reg_write(ADDR_USB, DATA_W'({pat, 1'b0}));
      @(negedge clk);
      check_value("pullup_p", 32'(pullup_p), 32'(pat[0] & pat[1]));
      check_value("pullup_n", 32'(pullup_n), 32'(pat[2] & pat[3]));
    end

    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: build.f
design/io_pkg.sv
design/io_reg_arbiter.sv
design/io_reg_file.sv
design/pad_bank.sv
design/usb_overlay.sv
design/strap_sampler.sv
design/io_top.sv
sim/io_top_assert.sv
sim/tb_io_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_io_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
